// File: logic/cpuPkg.sv
package cpuPkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      regAddr_t;
    typedef logic [2:0]      aluOp_t;
    typedef logic [2:0]      immType_t;

    localparam aluOp_t aluAdd   = 3'b000;
    localparam aluOp_t aluSub   = 3'b001;
    localparam aluOp_t aluAnd   = 3'b010;
    localparam aluOp_t aluSlt   = 3'b011;
    localparam aluOp_t aluPassB = 3'b110; // lui
    localparam aluOp_t aluOr    = 3'b111;

    localparam immType_t immNone = 3'b000;
    localparam immType_t immI    = 3'b001;
    localparam immType_t immS    = 3'b010;
    localparam immType_t immB    = 3'b011;
    localparam immType_t immU    = 3'b100;
    localparam immType_t immJ    = 3'b101;

    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opJal    = 7'b1101111;

    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Add  = 3'b000; // also sub
    localparam logic [2:0] f3Slt  = 3'b010;
    localparam logic [2:0] f3And  = 3'b111;
    localparam logic [2:0] f3Word = 3'b010; // lw / sw

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Sub  = 7'b0100000;

    localparam word_t resetPc = '0;

endpackage

// File: logic/immDecoder.sv
module immDecoder (
    input  cpuPkg::immType_t immType,
    input  cpuPkg::word_t    instruction,
    output cpuPkg::word_t    imm
);

    always_comb begin
        case (immType)
            cpuPkg::immI: begin
                imm = {{20{instruction[31]}}, instruction[31:20]};
            end
            cpuPkg::immS: begin
                imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            cpuPkg::immB: begin
                imm = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            end
            cpuPkg::immU: begin
                imm = {instruction[31:12], 12'b0};
            end
            cpuPkg::immJ: begin
                imm = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            end
            default: begin
                imm = '0; // R-type and unknown
            end
        endcase
    end

endmodule

// File: logic/regFile.sv
module regFile (
    input  logic             clk,
    input  cpuPkg::regAddr_t rs1Addr,
    input  cpuPkg::regAddr_t rs2Addr,
    input  cpuPkg::regAddr_t rdAddr,
    input  cpuPkg::word_t    rdData,
    input  logic             writeEn,
    output cpuPkg::word_t    rs1Data,
    output cpuPkg::word_t    rs2Data
);

    cpuPkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (writeEn && rdAddr != '0) begin
            regs[rdAddr] <= rdData;
        end
    end

    // x0 hardwired
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// File: logic/alu.sv
module alu (
    input  cpuPkg::word_t  srcA,
    input  cpuPkg::word_t  srcB,
    input  cpuPkg::aluOp_t aluOp,
    output cpuPkg::word_t  result,
    output logic           zero
);

    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd:   result = srcA + srcB;
            cpuPkg::aluSub:   result = srcA - srcB;
            cpuPkg::aluAnd:   result = srcA & srcB;
            cpuPkg::aluOr:    result = srcA | srcB;
            cpuPkg::aluSlt:   result = {{(cpuPkg::xlen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            cpuPkg::aluPassB: result = srcB;
            default:          result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: logic/controlUnit.sv
module controlUnit (
    input  cpuPkg::word_t    instruction,
    output cpuPkg::immType_t immType,
    output cpuPkg::aluOp_t   aluOp,
    output logic             memWrite,
    output logic             regWrite,
    output logic             aluSrcImm,
    output logic             memToReg,
    output logic             branchEq,
    output logic             branchNe,
    output logic             branchLt,
    output logic             jump,
    output logic             jumpReg,
    output logic             srcAPc
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    always_comb begin
        immType   = cpuPkg::immNone; // unknown encodings fall through as a no-op
        aluOp     = cpuPkg::aluAdd;
        memWrite  = 1'b0;
        regWrite  = 1'b0;
        aluSrcImm = 1'b0;
        memToReg  = 1'b0;
        branchEq  = 1'b0;
        branchNe  = 1'b0;
        branchLt  = 1'b0;
        jump      = 1'b0;
        jumpReg   = 1'b0;
        srcAPc    = 1'b0;
        case (opcode)
            cpuPkg::opLoad: begin
                if (funct3 == cpuPkg::f3Word) begin
                    immType   = cpuPkg::immI;
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    memToReg  = 1'b1;
                end
            end
            cpuPkg::opOpImm: begin
                if (funct3 == cpuPkg::f3Add) begin // addi only
                    immType   = cpuPkg::immI;
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                end
            end
            cpuPkg::opStore: begin
                if (funct3 == cpuPkg::f3Word) begin
                    immType   = cpuPkg::immS;
                    memWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                end
            end
            cpuPkg::opOp: begin
                if (funct7 == cpuPkg::f7Base) begin
                    case (funct3)
                        cpuPkg::f3Add: regWrite = 1'b1;
                        cpuPkg::f3Slt: begin
                            aluOp    = cpuPkg::aluSlt;
                            regWrite = 1'b1;
                        end
                        cpuPkg::f3And: begin
                            aluOp    = cpuPkg::aluAnd;
                            regWrite = 1'b1;
                        end
                        default: ;
                    endcase
                end else if (funct7 == cpuPkg::f7Sub && funct3 == cpuPkg::f3Add) begin
                    aluOp    = cpuPkg::aluSub;
                    regWrite = 1'b1;
                end
            end
            cpuPkg::opBranch: begin
                case (funct3)
                    cpuPkg::f3Beq: begin
                        immType  = cpuPkg::immB;
                        aluOp    = cpuPkg::aluSub;
                        branchEq = 1'b1;
                    end
                    cpuPkg::f3Bne: begin
                        immType  = cpuPkg::immB;
                        aluOp    = cpuPkg::aluSub;
                        branchNe = 1'b1;
                    end
                    cpuPkg::f3Blt: begin
                        immType  = cpuPkg::immB;
                        aluOp    = cpuPkg::aluSlt;
                        branchLt = 1'b1;
                    end
                    default: ;
                endcase
            end
            cpuPkg::opJalr: begin
                immType   = cpuPkg::immI;
                regWrite  = 1'b1;
                aluSrcImm = 1'b1; // target from alu
                jumpReg   = 1'b1;
            end
            cpuPkg::opJal: begin
                immType  = cpuPkg::immJ;
                regWrite = 1'b1;
                jump     = 1'b1;
            end
            cpuPkg::opLui: begin
                immType   = cpuPkg::immU;
                aluOp     = cpuPkg::aluPassB;
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            cpuPkg::opAuipc: begin
                immType   = cpuPkg::immU;
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                srcAPc    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/singleCycleCpu.sv
module singleCycleCpu (
    input  logic          clk,
    input  logic          reset,
    output cpuPkg::word_t pc,
    input  cpuPkg::word_t instruction,
    output logic          we,
    output cpuPkg::word_t addressToMem,
    output cpuPkg::word_t dataToMem,
    input  cpuPkg::word_t dataFromMem
);

    cpuPkg::immType_t immType;
    cpuPkg::aluOp_t   aluOp;
    logic             memWrite;
    logic             regWrite;
    logic             aluSrcImm;
    logic             memToReg;
    logic             branchEq;
    logic             branchNe;
    logic             branchLt;
    logic             jump;
    logic             jumpReg;
    logic             srcAPc;

    cpuPkg::word_t imm;
    cpuPkg::word_t rs1Data;
    cpuPkg::word_t rs2Data;
    cpuPkg::word_t srcA;
    cpuPkg::word_t srcB;
    cpuPkg::word_t aluResult;
    cpuPkg::word_t rdData;
    cpuPkg::word_t pcPlus4;
    cpuPkg::word_t branchTarget;
    cpuPkg::word_t nextPc;
    logic          zero;
    logic          takeBranch;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= cpuPkg::resetPc;
        end else begin
            pc <= nextPc;
        end
    end

    assign pcPlus4 = pc + 32'd4;

    // beq/bne look at zero after sub, blt at the slt bit
    assign takeBranch = (branchEq & zero) | (branchNe & ~zero) | (branchLt & aluResult[0])
                      | jump | jumpReg;
    assign branchTarget = jumpReg ? aluResult : pc + imm; // jalr keeps bit 0
    assign nextPc       = takeBranch ? branchTarget : pcPlus4;

    assign srcA = srcAPc ? pc : rs1Data; // auipc
    assign srcB = aluSrcImm ? imm : rs2Data;

    assign rdData = memToReg ? dataFromMem
                  : (jump | jumpReg) ? pcPlus4
                  : aluResult;

    assign addressToMem = aluResult;
    assign dataToMem    = rs2Data;
    assign we           = memWrite & ~reset; // no stray store in reset

    controlUnit ctrl0 (
        .instruction (instruction),
        .immType     (immType),
        .aluOp       (aluOp),
        .memWrite    (memWrite),
        .regWrite    (regWrite),
        .aluSrcImm   (aluSrcImm),
        .memToReg    (memToReg),
        .branchEq    (branchEq),
        .branchNe    (branchNe),
        .branchLt    (branchLt),
        .jump        (jump),
        .jumpReg     (jumpReg),
        .srcAPc      (srcAPc)
    );

    immDecoder imm0 (
        .immType     (immType),
        .instruction (instruction),
        .imm         (imm)
    );

    regFile regs0 (
        .clk     (clk),
        .rs1Addr (instruction[19:15]),
        .rs2Addr (instruction[24:20]),
        .rdAddr  (instruction[11:7]),
        .rdData  (rdData),
        .writeEn (regWrite & ~reset),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    alu alu0 (
        .srcA   (srcA),
        .srcB   (srcB),
        .aluOp  (aluOp),
        .result (aluResult),
        .zero   (zero)
    );

endmodule

// File: verif/cpuAsserts.sv
module cpuAsserts (
    input logic          clk,
    input logic          reset,
    input logic          we,
    input cpuPkg::word_t pc
);
    timeunit 1ns;
    timeprecision 100ps;

    noStoreInReset: assert property (@(posedge clk) reset |-> !we)
        else $error("we high while reset is asserted");

    pcAfterReset: assert property (@(posedge clk) reset |=> pc == cpuPkg::resetPc)
        else $error("pc not at the reset vector after a reset cycle");

    pcKnown: assert property (@(posedge clk) !reset |-> !$isunknown(pc))
        else $error("pc unknown after reset");

endmodule

bind singleCycleCpu cpuAsserts asserts0 (
    .clk   (clk),
    .reset (reset),
    .we    (we),
    .pc    (pc)
);

// File: include/cpuRefModel.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// executes one instruction; mem is keyed by word address
function automatic void refStep(
    input  cpuPkg::word_t instr,
    inout  cpuPkg::word_t pcModel,
    inout  cpuPkg::word_t regs [32],
    inout  cpuPkg::word_t mem [cpuPkg::word_t],
    output logic          storeEn,
    output cpuPkg::word_t storeAddr,
    output cpuPkg::word_t storeData
);
    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    cpuPkg::word_t a;
    cpuPkg::word_t b;
    cpuPkg::word_t immI;
    cpuPkg::word_t immS;
    cpuPkg::word_t immB;
    cpuPkg::word_t immU;
    cpuPkg::word_t immJ;
    cpuPkg::word_t ea;
    cpuPkg::word_t rdVal;
    cpuPkg::word_t nextPc;
    logic          wr;

    opcode = instr[6:0];
    funct3 = instr[14:12];
    funct7 = instr[31:25];
    a      = regs[instr[19:15]];
    b      = regs[instr[24:20]];
    immI   = {{20{instr[31]}}, instr[31:20]};
    immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    immB   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    immU   = {instr[31:12], 12'b0};
    immJ   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    nextPc = pcModel + 32'd4;
    rdVal  = '0;
    wr     = 1'b0;
    storeEn   = 1'b0;
    storeAddr = '0;
    storeData = '0;

    case (opcode)
        cpuPkg::opLoad: begin
            if (funct3 == cpuPkg::f3Word) begin
                ea    = a + immI;
                rdVal = mem.exists(ea >> 2) ? mem[ea >> 2] : '0;
                wr    = 1'b1;
            end
        end
        cpuPkg::opOpImm: begin
            if (funct3 == cpuPkg::f3Add) begin
                rdVal = a + immI;
                wr    = 1'b1;
            end
        end
        cpuPkg::opStore: begin
            if (funct3 == cpuPkg::f3Word) begin
                ea        = a + immS;
                storeEn   = 1'b1;
                storeAddr = ea;
                storeData = b;
                mem[ea >> 2] = b;
            end
        end
        cpuPkg::opOp: begin
            wr = 1'b1;
            if (funct7 == cpuPkg::f7Base && funct3 == cpuPkg::f3Add) begin
                rdVal = a + b;
            end else if (funct7 == cpuPkg::f7Sub && funct3 == cpuPkg::f3Add) begin
                rdVal = a - b;
            end else if (funct7 == cpuPkg::f7Base && funct3 == cpuPkg::f3Slt) begin
                rdVal = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end else if (funct7 == cpuPkg::f7Base && funct3 == cpuPkg::f3And) begin
                rdVal = a & b;
            end else begin
                wr = 1'b0; // div, rem and friends
            end
        end
        cpuPkg::opBranch: begin
            if ((funct3 == cpuPkg::f3Beq && a == b) ||
                (funct3 == cpuPkg::f3Bne && a != b) ||
                (funct3 == cpuPkg::f3Blt && $signed(a) < $signed(b))) begin
                nextPc = pcModel + immB;
            end
        end
        cpuPkg::opJal: begin
            rdVal  = pcModel + 32'd4;
            wr     = 1'b1;
            nextPc = pcModel + immJ;
        end
        cpuPkg::opJalr: begin
            rdVal  = pcModel + 32'd4;
            wr     = 1'b1;
            nextPc = a + immI; // bit 0 not cleared
        end
        cpuPkg::opLui: begin
            rdVal = immU;
            wr    = 1'b1;
        end
        cpuPkg::opAuipc: begin
            rdVal = pcModel + immU;
            wr    = 1'b1;
        end
        default: ;
    endcase

    if (wr && instr[11:7] != 5'd0) begin
        regs[instr[11:7]] = rdVal;
    end
    pcModel = nextPc;
endfunction

`endif

// File: verif/cpuTb.sv
module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int progDepth   = 256;
    localparam int dataDepth   = 256;
    localparam int resetCycles = 5;
    localparam int seed        = 49104;
    localparam int maxCycles   = 1000;
    localparam int dumpOffset  = 'h100; // final register dump area

    logic          clk;
    logic          reset;
    cpuPkg::word_t pc;
    cpuPkg::word_t instruction;
    logic          we;
    cpuPkg::word_t addressToMem;
    cpuPkg::word_t dataToMem;
    cpuPkg::word_t dataFromMem;

    cpuPkg::word_t progMem [progDepth];
    cpuPkg::word_t dataMem [dataDepth];
    int            progLen;
    cpuPkg::word_t haltPc;
    cpuPkg::word_t modelPc;
    cpuPkg::word_t modelRegs [32];
    cpuPkg::word_t modelMem [cpuPkg::word_t];
    logic          storeSeen;
    cpuPkg::word_t storeAddrSeen;
    cpuPkg::word_t storeDataSeen;
    logic          finished;
    int            errorCount;
    int            timeoutCount;
    int            cycles;

    `include "cpuRefModel.svh"

    singleCycleCpu dut0 (
        .clk          (clk),
        .reset        (reset),
        .pc           (pc),
        .instruction  (instruction),
        .we           (we),
        .addressToMem (addressToMem),
        .dataToMem    (dataToMem),
        .dataFromMem  (dataFromMem)
    );

    always #2 clk = ~clk;

    // combinational memories
    assign instruction = $isunknown(pc) ? '0 : progMem[pc[9:2]];
    assign dataFromMem = $isunknown(addressToMem) ? '0 : dataMem[addressToMem[9:2]];

    always @(posedge clk) begin
        storeSeen     <= we; // kept for the compare process
        storeAddrSeen <= addressToMem;
        storeDataSeen <= dataToMem;
        if (we) begin
            dataMem[addressToMem[9:2]] <= dataToMem;
        end
    end

    function automatic cpuPkg::word_t rType(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), cpuPkg::opOp};
    endfunction

    function automatic cpuPkg::word_t iType(input logic [6:0] op, input logic [2:0] f3,
                                            input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic cpuPkg::word_t sType(input int rs1, input int rs2, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), cpuPkg::f3Word, i[4:0], cpuPkg::opStore};
    endfunction

    function automatic cpuPkg::word_t bType(input logic [2:0] f3, input int rs1, input int rs2,
                                            input int imm);
        logic [12:0] i;
        i = 13'(imm);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], cpuPkg::opBranch};
    endfunction

    function automatic cpuPkg::word_t uType(input logic [6:0] op, input int rd,
                                            input logic [19:0] upper);
        return {upper, 5'(rd), op};
    endfunction

    function automatic cpuPkg::word_t jType(input int rd, input int imm);
        logic [20:0] i;
        i = 21'(imm);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), cpuPkg::opJal};
    endfunction

    function automatic cpuPkg::word_t fillWord(input int idx);
        logic [7:0] a;
        a = 8'(idx);
        return {a, ~a, a ^ 8'h5a, 8'hc3};
    endfunction

    task automatic emit(input cpuPkg::word_t instr);
        progMem[progLen] = instr;
        progLen++;
    endtask

    task automatic addImm(input int rd, input int rs1, input int imm);
        emit(iType(cpuPkg::opOpImm, cpuPkg::f3Add, rd, rs1, imm));
    endtask

    task automatic storeWord(input int rs2, input int offset);
        emit(sType(31, rs2, offset)); // x31 holds the data base
    endtask

    task automatic branchOverMarker(input logic [2:0] f3, input int rs1, input int rs2);
        emit(bType(f3, rs1, rs2, 8));
        addImm(24, 24, 1); // counts branches not taken
    endtask

    task automatic buildProgram();
        cpuPkg::word_t v;
        int            rs1;
        int            rs2;
        for (int i = 0; i < progDepth; i++) begin
            progMem[i] = iType(cpuPkg::opOpImm, cpuPkg::f3Add, 0, 0, i); // nop per address
        end
        progLen = 0;
        emit(sType(0, 0, 0)); // store sits on the reset vector
        for (int r = 1; r <= 30; r++) begin
            v = $urandom;
            emit(uType(cpuPkg::opLui, r, v[31:12]));
            addImm(r, r, int'(v[11:0]));
        end
        addImm(31, 0, 'h200);
        addImm(9, 0, -7); // negative operand
        addImm(25, 0, 5);
        addImm(24, 0, 0);
        for (int k = 0; k < 12; k++) begin
            rs1 = int'($urandom_range(10, 1));
            rs2 = int'($urandom_range(10, 1));
            case (k % 5)
                0: emit(rType(cpuPkg::f7Base, cpuPkg::f3Add, 11 + k, rs1, rs2));
                1: emit(rType(cpuPkg::f7Sub, cpuPkg::f3Add, 11 + k, rs1, rs2));
                2: emit(rType(cpuPkg::f7Base, cpuPkg::f3And, 11 + k, rs1, rs2));
                3: emit(rType(cpuPkg::f7Base, cpuPkg::f3Slt, 11 + k, rs1, 9));
                default: addImm(11 + k, rs1, int'($urandom_range(4095, 0)) - 2048);
            endcase
            storeWord(11 + k, 4 * k);
        end
        v = $urandom;
        emit(uType(cpuPkg::opLui, 23, v[31:12]));
        storeWord(23, 48);
        v = $urandom;
        emit(uType(cpuPkg::opAuipc, 26, v[31:12]));
        storeWord(26, 52);
        storeWord(5, 64);
        emit(iType(cpuPkg::opLoad, cpuPkg::f3Word, 27, 31, 64)); // reads back x5
        storeWord(27, 68);
        emit(iType(cpuPkg::opLoad, cpuPkg::f3Word, 28, 31, 'h1f0)); // untouched word
        storeWord(28, 72);
        branchOverMarker(cpuPkg::f3Beq, 1, 1);
        branchOverMarker(cpuPkg::f3Beq, 1, 2);
        branchOverMarker(cpuPkg::f3Bne, 1, 2);
        branchOverMarker(cpuPkg::f3Bne, 3, 3);
        branchOverMarker(cpuPkg::f3Blt, 9, 25);
        branchOverMarker(cpuPkg::f3Blt, 25, 9);
        storeWord(24, 76);
        emit(jType(29, 8));
        addImm(24, 24, 1); // skipped by jal
        storeWord(29, 80);
        emit(uType(cpuPkg::opAuipc, 30, 20'h0));
        emit(iType(cpuPkg::opJalr, 3'b000, 26, 30, 12)); // lands past the marker
        addImm(24, 24, 1);
        storeWord(30, 84);
        storeWord(26, 88);
        emit(jType(0, 4));
        addImm(0, 1, 77); // x0 stays zero
        storeWord(0, 92);
        emit(rType(7'b0000001, 3'b100, 11, 1, 2)); // div x11, x1, x2
        for (int r = 1; r < 32; r++) begin
            storeWord(r, dumpOffset + 4 * r);
        end
        haltPc = 32'(progLen * 4);
        emit(jType(0, 0));
    endtask

    task automatic initModel();
        modelPc = cpuPkg::resetPc;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        for (int i = 0; i < dataDepth; i++) begin
            dataMem[i]            = fillWord(i);
            modelMem[32'(i)]      = fillWord(i);
        end
    endtask

    task automatic checkValue(input cpuPkg::word_t got, input cpuPkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one model step per retired instruction
    always @(negedge clk) begin
        logic          expStore;
        cpuPkg::word_t expAddr;
        cpuPkg::word_t expData;
        if (!reset && !finished) begin
            refStep(progMem[modelPc[9:2]], modelPc, modelRegs, modelMem,
                    expStore, expAddr, expData);
            checkValue(32'(storeSeen), 32'(expStore), "store enable");
            if (expStore) begin
                checkValue(storeAddrSeen, expAddr, "store address");
                checkValue(storeDataSeen, expData, "store data");
            end
            checkValue(pc, modelPc, "pc");
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        finished     = 1'b0;
        errorCount   = 0;
        timeoutCount = 0;
        void'($urandom(seed));
        buildProgram();
        initModel();
        for (int i = 0; i < resetCycles; i++) begin
            @(negedge clk);
            checkValue(32'(we), 32'd0, "store enable in reset");
        end
        checkValue(pc, cpuPkg::resetPc, "pc in reset");
        reset  <= 1'b0;
        cycles = 0;
        while (pc !== haltPc && cycles < maxCycles) begin
            @(negedge clk);
            cycles++;
        end
        if (pc !== haltPc) begin
            timeoutCount++;
            $display("timeout: pc never reached the halt loop at %h", haltPc);
        end
        repeat (3) @(negedge clk); // a few laps of the self-jump
        finished <= 1'b1;
        @(posedge clk);
        $display("checks done: %0d errors, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+include
logic/cpuPkg.sv
logic/immDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/controlUnit.sv
logic/singleCycleCpu.sv
verif/cpuAsserts.sv
verif/cpuTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f src.f --top-module cpuTb \
    && ./obj_dir/VcpuTb > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^RESULT: PASS$" sim.log && exit 0 || exit 1
